// ==== hw/cpu_isa_pkg.sv ====
package cpu_isa_pkg;

    ////////////////////////////////////////////////////////////
    // basic types
    ////////////////////////////////////////////////////////////

    localparam int OPCODE_W   = 8;
    localparam int REG_ADDR_W = 2;

    typedef logic [OPCODE_W-1:0]   opcode_t;   // one instruction byte
    typedef logic [REG_ADDR_W-1:0] reg_addr_t; // register file address

    // instruction classes seen by the sequencer
    // nine classes, so the enum needs four bits
    typedef enum logic [3:0] {
        CLS_LD,
        CLS_WR,
        CLS_RD,
        CLS_WRIO,
        CLS_JMP,
        CLS_JMPC,
        CLS_NOOP,
        CLS_BRK,
        CLS_ALU
    } instr_class_e;

    // what drives the reg file write data port
    typedef enum logic [1:0] {
        SRC_ALU  = 2'b00, // alu result bus
        SRC_DMEM = 2'b01, // data memory read data
        SRC_IMM  = 2'b10  // immediate byte from the opcode register
    } wb_src_e;

    ////////////////////////////////////////////////////////////
    // opcode patterns, ? bits are wildcards for ==?
    ////////////////////////////////////////////////////////////

    localparam opcode_t LD_PAT   = 8'b1001??11; // load immediate, k follows
    localparam opcode_t WR_PAT   = 8'b1010????; // reg -> dmem
    localparam opcode_t RD_PAT   = 8'b1011????; // dmem -> reg
    localparam opcode_t JMP_PAT  = 8'b11000000; // jump, target follows
    localparam opcode_t JMPC_PAT = 8'b11001???; // jump on masked flags
    localparam opcode_t WRIO_PAT = 8'b111000??; // dmem -> io register
    localparam opcode_t NOOP_PAT = 8'b11110000;
    localparam opcode_t BRK_PAT  = 8'b11111111; // halt in decode

    ////////////////////////////////////////////////////////////
    // field positions inside the instruction byte
    ////////////////////////////////////////////////////////////

    localparam int DST_FIELD_LSB = 2; // dst reg is bits 3:2
    localparam int COND_Z_BIT    = 1; // jmpc mask bits
    localparam int COND_C_BIT    = 2;
    localparam int COND_N_BIT    = 0;

endpackage

// ==== hw/ctrl_seq_pkg.sv ====
package ctrl_seq_pkg;

    // sequencer states
    typedef enum logic [3:0] {
        ST_RESET,
        ST_WAIT,       // down counter, then go to the return target
        ST_CLEAR,      // drop stray enables before decode
        ST_DECODE,
        ST_SETUP_ALU,  // reg file drives alu operands
        ST_SETUP_MEM,  // reg file drives dmem address / data
        ST_WRITE_BACK,
        ST_WRITE_DMEM,
        ST_WRITE_IO,
        ST_JUMP
    } seq_state_e;

    ////////////////////////////////////////////////////////////
    // wait counts, extra cycles spent in ST_WAIT
    ////////////////////////////////////////////////////////////

    localparam int WAIT_W = 2;
    typedef logic [WAIT_W-1:0] wait_cnt_t;

    localparam wait_cnt_t FETCH_WAIT  = 2'd3; // pc inc + imem read + opcode reg
    localparam wait_cnt_t IMM_WAIT    = 2'd2; // immediate byte reaches opcode reg
    localparam wait_cnt_t DMEM_WAIT   = 2'd1; // dmem write completes
    localparam wait_cnt_t JUMP_SETTLE = 2'd2; // pc load settles

    ////////////////////////////////////////////////////////////
    // structs
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic z; // zero
        logic c; // carry
        logic n; // negative
    } flags_t;

    // cond_mask is laid out like flags_t, {z, c, n}
    typedef struct packed {
        cpu_isa_pkg::instr_class_e    iclass;
        cpu_isa_pkg::reg_addr_t       dst_addr;
        logic [$bits(flags_t)-1:0]    cond_mask;
    } decoded_t;

    typedef struct packed {
        cpu_isa_pkg::wb_src_e   wb_sel;        // reg file write data select
        logic                   wr_en_reg;
        logic                   wr_en_dmem;
        logic                   wr_en_io;
        logic                   inc_en;        // pc increment
        logic                   jmp_en;        // pc load
        logic                   use_strd_addr; // reg file takes wr_addr, not opcode[3:2]
        cpu_isa_pkg::reg_addr_t wr_addr;       // ld destination
    } ctrl_out_t;

    localparam ctrl_out_t CTRL_IDLE = '{
        wb_sel:        cpu_isa_pkg::SRC_ALU,
        wr_en_reg:     1'b0,
        wr_en_dmem:    1'b0,
        wr_en_io:      1'b0,
        inc_en:        1'b0,
        jmp_en:        1'b0,
        use_strd_addr: 1'b0,
        wr_addr:       2'b00
    };

endpackage

// ==== hw/opcode_decoder.sv ====
`timescale 1ns/100ps

module opcode_decoder
    import cpu_isa_pkg::*;
    import ctrl_seq_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  opcode_t  instruction, // raw byte from instruction memory
    output opcode_t  opcode,      // registered byte, also the immediate for ld
    output decoded_t decoded
);

    opcode_t opcode_q;

    ////////////////////////////////////////////////////////////
    // opcode register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            opcode_q <= '0; // 0x00 decodes as alu, harmless before first decode
        end else begin
            opcode_q <= instruction;
        end
    end

    assign opcode = opcode_q;

    ////////////////////////////////////////////////////////////
    // classification
    ////////////////////////////////////////////////////////////

    // first match wins, anything unmatched is an alu op
    function automatic instr_class_e classify(input opcode_t op);
        instr_class_e cls;
        if (op ==? LD_PAT) begin
            cls = CLS_LD;
        end else if (op ==? WR_PAT) begin
            cls = CLS_WR;
        end else if (op ==? RD_PAT) begin
            cls = CLS_RD;
        end else if (op ==? JMP_PAT) begin
            cls = CLS_JMP;
        end else if (op ==? JMPC_PAT) begin
            cls = CLS_JMPC;
        end else if (op ==? WRIO_PAT) begin
            cls = CLS_WRIO;
        end else if (op ==? NOOP_PAT) begin
            cls = CLS_NOOP;
        end else if (op ==? BRK_PAT) begin
            cls = CLS_BRK;
        end else begin
            cls = CLS_ALU; // incl. call / ret bytes, not part of this isa
        end
        return cls;
    endfunction

    always_comb begin
        decoded.iclass   = classify(opcode_q);
        decoded.dst_addr = opcode_q[DST_FIELD_LSB +: REG_ADDR_W]; // only meaningful for ld
        // mask bits reordered to match flags_t {z, c, n}
        decoded.cond_mask = {opcode_q[COND_Z_BIT],
                             opcode_q[COND_C_BIT],
                             opcode_q[COND_N_BIT]};
    end

endmodule

// ==== hw/flag_tracker.sv ====
`timescale 1ns/100ps

module flag_tracker
    import ctrl_seq_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  flags_t     alu_flags,    // live alu flags, change every cycle
    input  logic       capture,      // one cycle, end of an alu op
    input  logic [2:0] cond_mask,    // {z, c, n} from the jmpc byte
    output logic       branch_taken
);

    flags_t flags_q; // flags of the last alu instruction

    ////////////////////////////////////////////////////////////
    // hold register
    ////////////////////////////////////////////////////////////

    // the alu runs all the time, so only the alu write back may
    // update the held copy
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flags_q <= '0;
        end else if (capture) begin
            flags_q <= alu_flags;
        end
    end

    ////////////////////////////////////////////////////////////
    // branch condition
    ////////////////////////////////////////////////////////////

    // any masked flag set -> take the jump
    always_comb begin
        branch_taken = (flags_q.z & cond_mask[2])  // jmpz
                     | (flags_q.c & cond_mask[1])  // jmpc
                     | (flags_q.n & cond_mask[0]); // jmpn
    end

endmodule

// ==== hw/control_sequencer.sv ====
`timescale 1ns/100ps

module control_sequencer
    import cpu_isa_pkg::*;
    import ctrl_seq_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  decoded_t  decoded,
    input  logic      branch_taken, // from flag_tracker, used by jmpc only
    output logic      capture,      // load held flags this edge
    output ctrl_out_t ctrl
);

    seq_state_e state_q, state_d;
    seq_state_e ret_q, ret_d;     // where wait goes when the count runs out
    wait_cnt_t  cnt_q, cnt_d;     // wait down counter
    ctrl_out_t  ctrl_q, ctrl_d;   // registered outputs

    ////////////////////////////////////////////////////////////
    // registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= ST_RESET;
            ret_q   <= ST_DECODE;
            cnt_q   <= '0;
            ctrl_q  <= CTRL_IDLE;
        end else begin
            state_q <= state_d;
            ret_q   <= ret_d;
            cnt_q   <= cnt_d;
            ctrl_q  <= ctrl_d;
        end
    end

    assign ctrl = ctrl_q;

    // leaving wait toward write back, alu path only
    // ld / rd also pass here but carry a different wb_sel
    assign capture = (state_q == ST_WAIT) && (cnt_q == '0)
                  && (ret_q == ST_WRITE_BACK) && (ctrl_q.wb_sel == SRC_ALU);

    ////////////////////////////////////////////////////////////
    // next state and next outputs
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        ret_d   = ret_q;
        cnt_d   = cnt_q;
        ctrl_d  = ctrl_q; // outputs hold unless a state changes them

        unique case (state_q)
            ST_RESET: begin
                // opcode reg not valid yet, one wait then clear
                cnt_d   = '0;
                ret_d   = ST_DECODE;
                state_d = ST_WAIT;
            end

            ST_CLEAR: begin
                ctrl_d.wr_en_reg  = 1'b0;
                ctrl_d.wr_en_dmem = 1'b0;
                ctrl_d.wr_en_io   = 1'b0;
                ctrl_d.inc_en     = 1'b0;
                ctrl_d.jmp_en     = 1'b0;
                state_d = ST_DECODE;
            end

            ST_DECODE: begin
                ctrl_d.wb_sel = SRC_ALU; // overridden by rd / ld
                ctrl_d.inc_en = 1'b1;    // every class but brk moves the pc
                unique case (decoded.iclass)
                    CLS_LD: begin
                        ctrl_d.wb_sel  = SRC_IMM;
                        ctrl_d.wr_addr = decoded.dst_addr; // lost once k arrives
                        ret_d   = ST_WRITE_BACK;
                        state_d = ST_SETUP_MEM;
                    end
                    CLS_WR: begin
                        ctrl_d.wr_en_dmem = 1'b1; // high together with inc_en
                        state_d = ST_WRITE_DMEM;
                    end
                    CLS_RD: begin
                        ctrl_d.wb_sel = SRC_DMEM;
                        ret_d   = ST_WRITE_BACK;
                        state_d = ST_SETUP_MEM;
                    end
                    CLS_WRIO: begin
                        ret_d   = ST_WRITE_IO;
                        state_d = ST_SETUP_MEM;
                    end
                    CLS_JMP: begin
                        cnt_d   = FETCH_WAIT; // wait for target byte
                        ret_d   = ST_JUMP;
                        state_d = ST_WAIT;
                    end
                    CLS_JMPC: begin
                        cnt_d   = FETCH_WAIT;
                        ret_d   = branch_taken ? ST_JUMP : ST_DECODE; // not taken acts as noop
                        state_d = ST_WAIT;
                    end
                    CLS_NOOP: begin
                        cnt_d   = FETCH_WAIT;
                        ret_d   = ST_DECODE;
                        state_d = ST_WAIT;
                    end
                    CLS_BRK: begin
                        ctrl_d = CTRL_IDLE; // pc frozen, sit in decode
                        ctrl_d.wr_addr = ctrl_q.wr_addr;
                        state_d = ST_DECODE;
                    end
                    default: begin // CLS_ALU
                        ret_d   = ST_WRITE_BACK;
                        state_d = ST_SETUP_ALU;
                    end
                endcase
            end

            ST_SETUP_ALU: begin
                ctrl_d.inc_en = 1'b0;
                cnt_d   = '0; // operands ready, alu result after one wait
                ret_d   = ST_WRITE_BACK;
                state_d = ST_WAIT;
            end

            ST_SETUP_MEM: begin
                ctrl_d.inc_en = 1'b0;
                if ((ret_q == ST_WRITE_BACK) && (ctrl_q.wb_sel == SRC_IMM)) begin
                    ctrl_d.use_strd_addr = 1'b1; // ld writes to the latched address
                    cnt_d = IMM_WAIT;            // k still on its way
                end else begin
                    cnt_d = '0;                  // rd / wrio, dmem output next cycle
                end
                state_d = ST_WAIT;
            end

            ST_WAIT: begin
                ctrl_d.inc_en = 1'b0; // ends the pulse raised in decode
                if (cnt_q != '0) begin
                    cnt_d = cnt_q - 1'b1;
                end else begin
                    unique case (ret_q)
                        ST_WRITE_BACK: ctrl_d.wr_en_reg = 1'b1;
                        ST_WRITE_IO:   ctrl_d.wr_en_io  = 1'b1;
                        ST_JUMP:       ctrl_d.jmp_en    = 1'b1;
                        default:       ;                // back to decode via clear
                    endcase
                    state_d = (ret_q == ST_DECODE) ? ST_CLEAR : ret_q;
                end
            end

            ST_WRITE_BACK: begin
                ctrl_d.wr_en_reg     = 1'b0;
                ctrl_d.use_strd_addr = 1'b0;
                ret_d = ST_DECODE;
                if (ctrl_q.wb_sel == SRC_IMM) begin
                    ctrl_d.inc_en = 1'b1; // skip past k, fetch next instruction
                    cnt_d = FETCH_WAIT;
                end else begin
                    cnt_d = '0;
                end
                state_d = ST_WAIT;
            end

            ST_WRITE_DMEM: begin
                ctrl_d.inc_en     = 1'b0;
                ctrl_d.wr_en_dmem = 1'b0;
                cnt_d   = DMEM_WAIT;
                ret_d   = ST_DECODE;
                state_d = ST_WAIT;
            end

            ST_WRITE_IO: begin
                ctrl_d.wr_en_io = 1'b0;
                cnt_d   = '0;
                ret_d   = ST_DECODE;
                state_d = ST_WAIT;
            end

            ST_JUMP: begin
                ctrl_d.jmp_en = 1'b0;
                cnt_d   = JUMP_SETTLE; // new instruction after pc load
                ret_d   = ST_DECODE;
                state_d = ST_WAIT;
            end

            default: begin
                state_d = ST_CLEAR;
            end
        endcase
    end

endmodule

// ==== hw/control_unit.sv ====
`timescale 1ns/100ps

module control_unit
    import cpu_isa_pkg::*;
    import ctrl_seq_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  opcode_t   instruction, // from instruction memory
    input  flags_t    alu_flags,   // live alu flags
    output opcode_t   opcode,      // registered instruction byte
    output ctrl_out_t ctrl         // enables for reg file, dmem, io and pc
);

    decoded_t decoded;
    logic     branch_taken;
    logic     capture;

    ////////////////////////////////////////////////////////////
    // decoder and flag hold side by side
    ////////////////////////////////////////////////////////////

    opcode_decoder u_opcode_decoder (
        .clk         (clk),
        .rst         (rst),
        .instruction (instruction),
        .opcode      (opcode),
        .decoded     (decoded)
    );

    flag_tracker u_flag_tracker (
        .clk          (clk),
        .rst          (rst),
        .alu_flags    (alu_flags),
        .capture      (capture),
        .cond_mask    (decoded.cond_mask),
        .branch_taken (branch_taken)
    );

    // sequencer combines class and branch decision
    control_sequencer u_control_sequencer (
        .clk          (clk),
        .rst          (rst),
        .decoded      (decoded),
        .branch_taken (branch_taken),
        .capture      (capture),
        .ctrl         (ctrl)
    );

endmodule

// ==== test/tb_control_unit.sv ====
`timescale 1ns/100ps

module tb_control_unit
    import cpu_isa_pkg::*;
    import ctrl_seq_pkg::*;
();

    // instruction kinds as the testbench sees them
    localparam int K_NOOP = 0; // also jmpc not taken
    localparam int K_ALU  = 1;
    localparam int K_RD   = 2;
    localparam int K_WRIO = 3;
    localparam int K_WR   = 4;
    localparam int K_LD   = 5;
    localparam int K_JUMP = 6; // jmp and jmpc taken
    localparam int K_BRK  = 7;

    logic      clk;
    logic      rst;
    opcode_t   instruction;
    flags_t    alu_flags;
    opcode_t   opcode;
    ctrl_out_t ctrl;

    string     names[$];
    opcode_t   bytes[$];
    flags_t    flag_vals[$];
    int        lens[$];
    reg_addr_t addrs[$];
    wb_src_e   wbs[$];

    int errors = 0;
    int cycles = 0;
    int limit  = 0; // 0 until the data file is read

    control_unit DUT (
        .clk         (clk),
        .rst         (rst),
        .instruction (instruction),
        .alu_flags   (alu_flags),
        .opcode      (opcode),
        .ctrl        (ctrl)
    );

    always #2 clk = ~clk; // 4 ns period

    ////////////////////////////////////////////////////////////
    // run limit
    ////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("error: timeout after %0d cycles, sequencer never got back to DECODE",
                     cycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////

    task automatic check_ctrl(input string what, input ctrl_out_t got, input ctrl_out_t exp);
        if (got !== exp) begin
            errors++;
            $display("** Error: ctrl %s got %h expected %h", what, got, exp);
        end
    endtask

    task automatic check_len(input string what, input int got, input int exp);
        if (got !== exp) begin
            errors++;
            $display("** Error: length %s got %h expected %h", what, got, exp);
        end
    endtask

    task automatic check_opcode(input string what, input opcode_t got, input opcode_t exp);
        if (got !== exp) begin
            errors++;
            $display("** Error: opcode %s got %h expected %h", what, got, exp);
        end
    endtask

    // kind from the isa opcode table, jmpc split by its expected length
    function automatic int kind_of(input opcode_t b, input int len);
        int kind;
        if (b[7:4] == 4'h9 && b[1:0] == 2'b11)  kind = K_LD;
        else if (b[7:4] == 4'ha)                 kind = K_WR;
        else if (b[7:4] == 4'hb)                 kind = K_RD;
        else if (b == 8'hc0)                     kind = K_JUMP;
        else if (b[7:3] == 5'b11001)             kind = (len == 10) ? K_JUMP : K_NOOP;
        else if (b[7:2] == 6'b111000)            kind = K_WRIO;
        else if (b == 8'hf0)                     kind = K_NOOP;
        else if (b == 8'hff)                     kind = K_BRK;
        else                                     kind = K_ALU;
        return kind;
    endfunction

    // ctrl seen after edge D+k
    function automatic ctrl_out_t expected_ctrl(input int kind, input int k,
                                                input wb_src_e wb, input reg_addr_t addr);
        ctrl_out_t e;
        e = '0;
        e.wb_sel        = wb;
        e.wr_addr       = addr;
        e.inc_en        = (kind != K_BRK) && (k == 1 || (kind == K_LD && k == 6));
        e.wr_en_reg     = ((kind == K_ALU || kind == K_RD) && k == 3) || (kind == K_LD && k == 5);
        e.wr_en_io      = (kind == K_WRIO) && (k == 3);
        e.wr_en_dmem    = (kind == K_WR) && (k == 1);
        e.jmp_en        = (kind == K_JUMP) && (k == 5);
        e.use_strd_addr = (kind == K_LD) && (k >= 2) && (k <= 5);
        return e;
    endfunction

    ////////////////////////////////////////////////////////////
    // stimulus and checks
    ////////////////////////////////////////////////////////////

    initial begin
        int        fd;
        string     line;
        string     nm;
        int        b, f, l, a, w;
        int        k;
        int        kind;
        int        errs_before;
        int        passed;
        int        failed;
        bit        done;
        opcode_t   next_byte;
        wb_src_e   prev_wb;
        reg_addr_t prev_addr;
        ctrl_out_t reset_exp;

        clk         = 1'b0;
        rst         = 1'b1;
        instruction = '0;
        alu_flags   = '0;
        passed      = 0;
        failed      = 0;
        prev_wb     = SRC_ALU;
        prev_addr   = '0;

        reset_exp        = '0; // every enable and the address low
        reset_exp.wb_sel = SRC_ALU;

        fd = $fopen("test/control_unit_testdata.txt", "r");
        if (fd == 0) begin
            $display("error: cannot open test/control_unit_testdata.txt");
            $display("STATUS: FAIL");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 0 && line[0] != 8'h23) begin // skip # lines
                    if ($sscanf(line, "%s %h %h %d %h %h", nm, b, f, l, a, w) == 6) begin
                        names.push_back(nm);
                        bytes.push_back(opcode_t'(b));
                        flag_vals.push_back(flags_t'(f));
                        lens.push_back(l);
                        addrs.push_back(reg_addr_t'(a));
                        wbs.push_back(wb_src_e'(w[1:0]));
                        limit += l;
                    end
                end
            end
            $fclose(fd);
            limit += 50;

            instruction = bytes[0];
            repeat (2) @(posedge clk);
            #0.5;
            check_ctrl("during reset", ctrl, reset_exp);
            rst = 1'b0;
            @(posedge clk);
            #0.5;
            check_opcode("after reset", opcode, bytes[0]); // one edge of latency
            while (DUT.u_control_sequencer.state_q != ST_DECODE) begin
                @(posedge clk);
                #0.5;
            end

            for (int i = 0; i < names.size(); i++) begin
                errs_before = errors;
                kind        = kind_of(bytes[i], lens[i]);
                next_byte   = (i + 1 < names.size()) ? bytes[i+1] : 8'hf0;
                instruction = next_byte;    // byte of test i already sits in opcode reg
                alu_flags   = flag_vals[i];
                k = 0;
                check_ctrl($sformatf("%s k=0", names[i]), ctrl,
                           expected_ctrl(kind, 0, prev_wb, prev_addr));
                done = 1'b0;
                while (!done) begin
                    @(posedge clk);
                    #0.5;
                    k++;
                    if (DUT.u_control_sequencer.state_q == ST_DECODE) begin
                        done = 1'b1;
                    end else begin
                        check_ctrl($sformatf("%s k=%0d", names[i], k), ctrl,
                                   expected_ctrl(kind, k, wbs[i], addrs[i]));
                    end
                end
                check_len(names[i], k, lens[i]);
                check_opcode(names[i], opcode, next_byte);
                prev_wb   = wbs[i];
                prev_addr = addrs[i];
                if (errors == errs_before) begin
                    passed++;
                    $display("test %-16s ok      L=%0d", names[i], k);
                end else begin
                    failed++;
                    $display("test %-16s failed  L=%0d", names[i], k);
                end
            end

            $display("tests %0d, passed %0d, failed %0d, errors %0d",
                     names.size(), passed, failed, errors);
            if (errors == 0) begin
                $display("STATUS: PASS");
            end else begin
                $display("STATUS: FAIL");
            end
            $finish;
        end
    end

endmodule

// ==== test/control_unit_testdata.txt ====
# name  instr  flags{z,c,n}  L(dec)  wr_addr  wb_sel(0 alu 1 dmem 2 imm)
# flags are driven for the whole test, only alu tests load them
reset_noop       f0 0 6  0 0
wr_a5            a5 0 5  0 0
rd_b3            b3 0 6  0 1
wrio_e2          e2 0 6  0 0
alu_zero         05 4 6  0 0
jmpz_taken       ca 0 10 0 0
jmpc_not_taken   cc 0 6  0 0
jmpn_not_taken   c9 0 6  0 0
ld_r0            93 0 11 0 2
ld_r3            9f 0 11 3 2
noop_after_ld    f0 0 6  3 0
jmp_c0           c0 0 10 3 0
alu_carry        05 2 6  3 0
jmpc_taken       cc 0 10 3 0
jmpz_not_taken   ca 0 6  3 0
noop_flags_set   f0 7 6  3 0
jmpz_still_not   ca 0 6  3 0
wr_flags_set     a5 7 5  3 0
jmpn_still_not   c9 0 6  3 0
alu_neg          05 1 6  3 0
jmpn_taken       c9 0 10 3 0
jmpc_not_again   cc 0 6  3 0
ld_r1            97 0 11 1 2
rd_after_ld      b3 0 6  1 1
brk_1            ff 0 1  1 0
brk_2            ff 0 1  1 0
brk_3            ff 0 1  1 0
noop_after_brk   f0 0 6  1 0
alu_last         05 0 6  1 0

// ==== control_unit.f ====
hw/cpu_isa_pkg.sv
hw/ctrl_seq_pkg.sv
hw/opcode_decoder.sv
hw/flag_tracker.sv
hw/control_sequencer.sv
hw/control_unit.sv
test/tb_control_unit.sv

// ==== Bender.yml ====
package:
  name: control_unit

sources:
  - hw/cpu_isa_pkg.sv
  - hw/ctrl_seq_pkg.sv
  - hw/opcode_decoder.sv
  - hw/flag_tracker.sv
  - hw/control_sequencer.sv
  - hw/control_unit.sv
  - target: test
    files:
      - test/tb_control_unit.sv
